/* design/bpu.sv */
`timescale 1ns/100ps

`include "frontend_defs.svh"

module bpu #(
    parameter int BTB_ROWS = `BTB_ROWS
) (
    input  logic                    clk,
    input  logic                    reset,

    // fetch register load from the master
    input  logic                    capture,
    input  frontend_pkg::t_paddr    cap_pc,
    input  frontend_pkg::t_rv_instr cap_instr,

    // resolved branches from execute
    input  logic                    train_valid,
    input  logic                    train_taken,
    input  frontend_pkg::t_paddr    train_pc,
    input  frontend_pkg::t_paddr    train_target,

    output logic                    pred_taken,
    output frontend_pkg::t_paddr    pred_target
);

    import frontend_pkg::*;

    logic       btb_hit;
    t_paddr     btb_target;
    logic       is_ctrl;
    logic [1:0] cntr;
    logic       cntr_inc;
    logic       cntr_dec;

    // only taken branches allocate
    btb #(
        .BTB_ROWS  (BTB_ROWS)
    ) i_btb (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (cap_pc),
        .hit       (btb_hit),
        .target    (btb_target),
        .wr_en     (train_valid && train_taken),
        .wr_pc     (train_pc),
        .wr_target (train_target)
    );

    // ************************************************************
    // global 2-bit counter
    // ************************************************************

    assign cntr_inc = train_valid && train_taken;
    assign cntr_dec = train_valid && !train_taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            cntr <= `CNTR_INIT;
        end else if (cntr_inc && (cntr != 2'b11)) begin
            cntr <= cntr + 2'b01;
        end else if (cntr_dec && (cntr != 2'b00)) begin
            cntr <= cntr - 2'b01;
        end
    end

    assign is_ctrl = opcode_is_control(cap_instr.opcode);

    // meaningful only while capture is high
    assign pred_taken  = capture && cntr[1] && btb_hit && is_ctrl;
    assign pred_target = btb_target;

    // only word aligned branches and targets enter the buffer
    a_train_aligned: assert property (@(posedge clk) disable iff (reset)
        train_valid && train_taken |-> train_pc[1:0] == 2'b00 && train_target[1:0] == 2'b00);

endmodule

/* design/btb.sv */
`timescale 1ns/100ps

`include "frontend_defs.svh"

module btb #(
    parameter int BTB_ROWS = `BTB_ROWS
) (
    input  logic                 clk,
    input  logic                 reset,

    // lookup side
    input  frontend_pkg::t_paddr lookup_pc,
    output logic                 hit,
    output frontend_pkg::t_paddr target,

    // training side
    input  logic                 wr_en,
    input  frontend_pkg::t_paddr wr_pc,
    input  frontend_pkg::t_paddr wr_target
);

    import frontend_pkg::*;

    localparam int IDX_W = $clog2(BTB_ROWS);

    logic   row_valid  [BTB_ROWS];
    t_paddr row_tag    [BTB_ROWS];
    t_paddr row_target [BTB_ROWS];

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] wr_idx;

    // word index, bits 1:0 are always zero
    assign lookup_idx = lookup_pc[2 +: IDX_W];
    assign wr_idx     = wr_pc[2 +: IDX_W];

    // ************************************************************
    // storage
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ROWS; i++) begin
                row_valid[i] <= 1'b0;
            end
        end else if (wr_en) begin
            row_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            row_tag[wr_idx]    <= wr_pc;
            row_target[wr_idx] <= wr_target;
        end
    end

    // ************************************************************
    // lookup
    // ************************************************************

    // full address tag, so aliasing rows never hit
    assign hit    = row_valid[lookup_idx] && (row_tag[lookup_idx] == lookup_pc);
    assign target = row_target[lookup_idx];

endmodule

/* design/fetch_wb_master.sv */
`timescale 1ns/100ps

module fetch_wb_master (
    input  logic                    clk,
    input  logic                    reset,

    input  frontend_pkg::t_paddr    fetch_pc_req,

    // wishbone classic, read only
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output frontend_pkg::t_paddr    wb_adr,
    input  logic                    wb_ack,
    input  frontend_pkg::t_rv_instr wb_rdata,

    input  logic                    redirect_valid,

    // predictor lookup on fetch register load
    output logic                    capture,
    output frontend_pkg::t_paddr    cap_pc,
    output frontend_pkg::t_rv_instr cap_instr,
    input  logic                    bpu_taken,
    input  frontend_pkg::t_paddr    bpu_target,

    // decode port
    output logic                    fetch_valid,
    output frontend_pkg::t_paddr    fetch_pc,
    output frontend_pkg::t_rv_instr fetch_instr,
    output logic                    pred_taken,
    output frontend_pkg::t_paddr    pred_target,
    input  logic                    decode_ready
);

    import frontend_pkg::*;

    logic   busy;
    logic   discard;
    logic   start;
    logic   accept;
    logic   done;
    t_paddr adr_q;

    assign accept = fetch_valid && decode_ready;
    assign done   = busy && wb_ack;

    // no read in a redirect cycle, pc_gen only has the new pc next cycle
    assign start = !busy && (!fetch_valid || decode_ready) && !redirect_valid;

    // ************************************************************
    // bus cycle
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            discard <= 1'b0;
        end else begin
            if (done) begin
                busy <= 1'b0;
            end else if (start) begin
                busy <= 1'b1;
            end
            // a redirect during a read kills its data when it returns
            if (done) begin
                discard <= 1'b0;
            end else if (busy && redirect_valid) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= fetch_pc_req;
        end
    end

    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_adr = adr_q;

    // ************************************************************
    // fetch register
    // ************************************************************

    assign capture   = done && !discard && !redirect_valid;
    assign cap_pc    = adr_q;
    assign cap_instr = wb_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else if (redirect_valid) begin
            fetch_valid <= 1'b0;
        end else if (capture) begin
            fetch_valid <= 1'b1;
        end else if (accept) begin
            fetch_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            fetch_pc    <= adr_q;
            fetch_instr <= wb_rdata;
            pred_taken  <= bpu_taken;
            pred_target <= bpu_target;
        end
    end

    // an ack outside a read would be lost
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> wb_cyc && wb_stb);

    a_adr_stable: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> $stable(wb_adr));

    // one read in flight and one instruction held, never more
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        capture |-> !fetch_valid || decode_ready);

endmodule

/* design/frontend_defs.svh */
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// ************************************************************
// fetch front end configuration
// ************************************************************

// rows in the branch target buffer, power of two
`define BTB_ROWS 32

// first fetch address out of reset
`define RESET_PC 32'h0000_1000

// global 2-bit counter starts weakly not taken
`define CNTR_INIT 2'b01

`endif

/* design/frontend_pkg.sv */
package frontend_pkg;

    // ************************************************************
    // address and instruction types
    // ************************************************************

    // byte address
    typedef logic [31:0] t_paddr;

    // only the control transfer opcodes are named
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } t_opcode;

    // r-type field layout, opcode sits in bits 6:0
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        t_opcode    opcode;
    } t_rv_instr;

    // ************************************************************
    // opcode helpers
    // ************************************************************

    // true for branch, jal and jalr
    function automatic logic opcode_is_control(input t_opcode op);
        logic is_ctrl;
        case (op)
            OP_BRANCH,
            OP_JAL,
            OP_JALR: begin
                is_ctrl = 1'b1;
            end
            default: begin
                is_ctrl = 1'b0;
            end
        endcase
        return is_ctrl;
    endfunction

endpackage

/* design/frontend_top.sv */
`timescale 1ns/100ps

module frontend_top (
    input  logic                    clk,
    input  logic                    reset,

    // wishbone classic master port
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output frontend_pkg::t_paddr    wb_adr,
    input  logic                    wb_ack,
    input  frontend_pkg::t_rv_instr wb_rdata,

    // training from execute
    input  logic                    train_valid,
    input  logic                    train_taken,
    input  frontend_pkg::t_paddr    train_pc,
    input  frontend_pkg::t_paddr    train_target,

    // redirect from execute
    input  logic                    redirect_valid,
    input  frontend_pkg::t_paddr    redirect_pc,

    // decode port
    output logic                    fetch_valid,
    output frontend_pkg::t_paddr    fetch_pc,
    output frontend_pkg::t_rv_instr fetch_instr,
    output logic                    pred_taken,
    output frontend_pkg::t_paddr    pred_target,
    input  logic                    decode_ready
);

    import frontend_pkg::*;

    t_paddr    fetch_pc_req;
    logic      capture;
    t_paddr    cap_pc;
    t_rv_instr cap_instr;
    logic      bpu_taken;
    t_paddr    bpu_target;

    pc_gen i_pc_gen (
        .clk             (clk),
        .reset           (reset),
        .capture         (capture),
        .cap_pred_taken  (bpu_taken),
        .cap_pc          (cap_pc),
        .cap_pred_target (bpu_target),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .fetch_pc_req    (fetch_pc_req)
    );

    fetch_wb_master i_fetch (
        .clk            (clk),
        .reset          (reset),
        .fetch_pc_req   (fetch_pc_req),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_ack         (wb_ack),
        .wb_rdata       (wb_rdata),
        .redirect_valid (redirect_valid),
        .capture        (capture),
        .cap_pc         (cap_pc),
        .cap_instr      (cap_instr),
        .bpu_taken      (bpu_taken),
        .bpu_target     (bpu_target),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .decode_ready   (decode_ready)
    );

    // prediction is looked up combinationally in the capture cycle
    bpu i_bpu (
        .clk          (clk),
        .reset        (reset),
        .capture      (capture),
        .cap_pc       (cap_pc),
        .cap_instr    (cap_instr),
        .train_valid  (train_valid),
        .train_taken  (train_taken),
        .train_pc     (train_pc),
        .train_target (train_target),
        .pred_taken   (bpu_taken),
        .pred_target  (bpu_target)
    );

endmodule

/* design/pc_gen.sv */
`timescale 1ns/100ps

`include "frontend_defs.svh"

module pc_gen (
    input  logic                 clk,
    input  logic                 reset,

    // fetch register load and its prediction
    input  logic                 capture,
    input  logic                 cap_pred_taken,
    input  frontend_pkg::t_paddr cap_pc,
    input  frontend_pkg::t_paddr cap_pred_target,

    // execute redirect
    input  logic                 redirect_valid,
    input  frontend_pkg::t_paddr redirect_pc,

    output frontend_pkg::t_paddr fetch_pc_req
);

    import frontend_pkg::*;

    t_paddr pc;
    t_paddr pc_nxt;

    // ************************************************************
    // next address select
    // ************************************************************

    // redirect wins over anything fetch decided
    always_comb begin
        pc_nxt = pc;
        if (redirect_valid) begin
            pc_nxt = redirect_pc;
        end else if (capture) begin
            if (cap_pred_taken) begin
                pc_nxt = cap_pred_target;
            end else begin
                pc_nxt = cap_pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_nxt;
        end
    end

    assign fetch_pc_req = pc;

    // targets from execute and the buffer must stay word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        fetch_pc_req[1:0] == 2'b00);

endmodule

/* filelist.f */
+incdir+design
design/frontend_pkg.sv
design/btb.sv
design/bpu.sv
design/pc_gen.sv
design/fetch_wb_master.sv
design/frontend_top.sv
test/tb_mem_model.sv
test/tb_frontend.sv

/* run.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_frontend -f filelist.f -o sim_frontend

./obj_dir/sim_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    exit 1
fi
exit 0

/* test/tb_frontend.sv */
`timescale 1ns/100ps

`include "frontend_defs.svh"

module tb_frontend;

    logic        clk;
    logic        reset;
    logic        wb_cyc, wb_stb, wb_ack;
    logic [31:0] wb_adr, wb_rdata;
    logic        train_valid, train_taken;
    logic [31:0] train_pc, train_target;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        fetch_valid, pred_taken, decode_ready;
    logic [31:0] fetch_pc, fetch_instr, pred_target;
    logic [1:0]  wait_sel;
    logic        stall;
    logic        ready_hold;
    logic        ready_rand;

    // reference model state
    logic        m_valid [32];
    logic [31:0] m_tag [32];
    logic [31:0] m_target [32];
    logic [1:0]  m_cntr;
    logic [31:0] exp_pc, exp_instr, exp_target;
    logic        exp_taken;
    logic [31:0] lfsr;
    int          accepted;

    frontend_top i_dut (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_ack(wb_ack), .wb_rdata(wb_rdata),
        .train_valid(train_valid), .train_taken(train_taken),
        .train_pc(train_pc), .train_target(train_target),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_instr(fetch_instr),
        .pred_taken(pred_taken), .pred_target(pred_target), .decode_ready(decode_ready)
    );

    tb_mem_model i_mem (
        .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_ack(wb_ack), .wb_rdata(wb_rdata), .wait_sel(wait_sel), .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // decode stalls while ready_hold is set
    assign decode_ready = !ready_hold && ready_rand;

    // ************************************************************
    // helpers
    // ************************************************************

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic is_ctrl_op(input logic [6:0] op);
        return op == 7'b1100011 || op == 7'b1101111 || op == 7'b1100111;
    endfunction

    // expected prediction for a word fetched at pc
    function automatic void predict(input logic [31:0] pc, input logic [31:0] instr,
                                    output logic taken, output logic [31:0] target);
        logic [4:0] idx;
        idx = pc[6:2];
        taken = m_cntr[1] && m_valid[idx] && (m_tag[idx] == pc) && is_ctrl_op(instr[6:0]);
        target = m_target[idx];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Some tests failed");
        $fatal(1, "timeout");
    endtask

    // execute sends training and redirect in one cycle
    task automatic send_redirect(input logic tv, input logic tk, input logic [31:0] tpc,
                                 input logic [31:0] ttgt, input logic [31:0] rpc);
        @(negedge clk);
        train_valid    = tv;
        train_taken    = tk;
        train_pc       = tpc;
        train_target   = ttgt;
        redirect_valid = 1'b1;
        redirect_pc    = rpc;
        if (tv && tk) begin
            m_valid[tpc[6:2]]  = 1'b1;
            m_tag[tpc[6:2]]    = tpc;
            m_target[tpc[6:2]] = ttgt;
            if (m_cntr != 2'b11) m_cntr = m_cntr + 2'b01;
        end else if (tv && m_cntr != 2'b00) begin
            m_cntr = m_cntr - 2'b01;
        end
        exp_pc = rpc;
        @(negedge clk);
        train_valid    = 1'b0;
        redirect_valid = 1'b0;
    endtask

    task automatic run_transfers(input int n);
        int goal;
        int cycles;
        goal = accepted + n;
        cycles = 0;
        while (accepted < goal) begin
            @(negedge clk);
            cycles++;
            if (cycles > n * 40 + 100) fail_timeout("accepted transfers");
        end
    endtask

    task automatic wait_bus_or_valid(input logic want_bus);
        int cycles;
        cycles = 0;
        while (want_bus ? !wb_cyc : !fetch_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > 200) fail_timeout(want_bus ? "a bus read" : "a held instruction");
        end
    endtask

    // ************************************************************
    // random inputs and the comparing process
    // ************************************************************

    always @(negedge clk) begin
        lfsr = lfsr_step(lfsr);
        wait_sel[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        wait_sel[1] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        ready_rand = lfsr[0];
        lfsr = lfsr_step(lfsr);
        ready_rand = ready_rand || lfsr[0];
    end

    // a transfer in a redirect cycle is discarded with the held entry
    always @(posedge clk) begin
        if (!reset && fetch_valid && decode_ready && !redirect_valid) begin
            exp_instr = i_mem.read_word(exp_pc);
            predict(exp_pc, exp_instr, exp_taken, exp_target);
            check_value("fetch_pc", fetch_pc, exp_pc);
            check_value("fetch_instr", fetch_instr, exp_instr);
            check_value("pred_taken", {31'b0, pred_taken}, {31'b0, exp_taken});
            if (exp_taken) begin
                check_value("pred_target", pred_target, exp_target);
            end
            exp_pc = exp_taken ? exp_target : exp_pc + 32'd4;
            accepted++;
        end
    end

    // ************************************************************
    // stimulus
    // ************************************************************

    initial begin
        reset = 1'b1;
        train_valid = 1'b0;
        train_taken = 1'b0;
        train_pc = '0;
        train_target = '0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        ready_rand = 1'b0;
        wait_sel = 2'd0;
        stall = 1'b0;
        ready_hold = 1'b0;
        lfsr = 32'd81185;
        for (int i = 0; i < 32; i++) m_valid[i] = 1'b0;
        m_cntr = `CNTR_INIT;
        exp_pc = `RESET_PC;
        accepted = 0;
        repeat (10) @(posedge clk);
        // branch, alias of its row, and a jal closing the long loop
        i_mem.write_word(32'h1100, 32'h0020_8463);
        i_mem.write_word(32'h1180, 32'h0040_0063);
        i_mem.write_word(32'h1440, 32'hCB1F_F06F);
        @(negedge clk);
        reset = 1'b0;

        run_transfers(12);
        send_redirect(1, 1, 32'h1100, 32'h1400, 32'h10F0);
        send_redirect(1, 1, 32'h1100, 32'h1400, 32'h10F8);
        run_transfers(6);

        // alias of the branch row, and a plain word trained taken at counter 3
        send_redirect(1, 1, 32'h118C, 32'h1300, 32'h1178);
        run_transfers(10);

        send_redirect(1, 0, 32'h1100, 32'h1400, 32'h10FC);
        run_transfers(4);
        for (int k = 0; k < 3; k++) begin
            send_redirect(1, 0, 32'h1100, 32'h1400, 32'h10FC);
            run_transfers(4);
        end
        send_redirect(1, 1, 32'h1100, 32'h1400, 32'h10FC);
        run_transfers(4);
        send_redirect(1, 1, 32'h1100, 32'h1400, 32'h10FC);
        run_transfers(4);

        // redirect over a stalled read, then over a held instruction
        stall = 1'b1;
        wait_bus_or_valid(1'b1);
        repeat (2) @(negedge clk);
        send_redirect(0, 0, '0, '0, 32'h1000);
        stall = 1'b0;
        run_transfers(4);
        ready_hold = 1'b1;
        wait_bus_or_valid(1'b0);
        send_redirect(0, 0, '0, '0, 32'h10F0);
        ready_hold = 1'b0;
        run_transfers(4);

        send_redirect(1, 1, 32'h1440, 32'h10F0, 32'h10F0);
        run_transfers(400);

        $display("All tests passed");
        $finish;
    end

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/100ps

module tb_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic [31:0] wb_adr,
    output logic        wb_ack,
    output logic [31:0] wb_rdata,
    // wait states for the next read, sampled when it starts
    input  logic [1:0]  wait_sel,
    // holds off ack while high
    input  logic        stall
);

    logic [31:0] mem [1024];
    logic        active;
    logic [1:0]  remaining;

    // ************************************************************
    // contents
    // ************************************************************

    // addi-type words, never a control transfer
    initial begin
        logic [31:0] addr;
        logic [31:0] hash;
        for (int i = 0; i < 1024; i++) begin
            addr = 32'(i) << 2;
            hash = (addr * 32'h9E37_79B9) ^ (addr >> 3);
            mem[i] = {hash[31:7], 7'b0010011};
        end
    end

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[11:2]] = data;
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return mem[addr[11:2]];
    endfunction

    // ************************************************************
    // bus slave
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            active    <= 1'b0;
            remaining <= 2'd0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
            active <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!active) begin
                active    <= 1'b1;
                remaining <= wait_sel;
            end else if (remaining != 2'd0) begin
                remaining <= remaining - 2'd1;
            end else if (!stall) begin
                wb_ack   <= 1'b1;
                wb_rdata <= mem[wb_adr[11:2]];
            end
        end
    end

endmodule
